/* vlog.f */
src/mips_mem_pkg.sv
src/mem_stage.sv
src/memwb_reg.sv
src/writeback.sv
src/reg_file.sv
src/cp0_regs.sv
src/mem_wb_top.sv
dv/tb_clock.sv
dv/tb_mem_wb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the MEM/WB testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mem_wb -f vlog.f --Mdir obj_dir -o tb_mem_wb_sim
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/tb_mem_wb_sim > "$LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "Simulation exited with an error, see $LOG"
    exit 1
fi

# Verdict comes from the log
if grep -q "Some tests failed" "$LOG"; then
    echo "FAIL, see $LOG"
    exit 1
fi
echo "PASS"
exit 0

/* dv/tb_mem_wb.sv */
`timescale 1ns/1ps

module tb_mem_wb import mips_mem_pkg::*; ();

    localparam int REGION  = 64;    // Words under test
    localparam int N_RAND  = 160;
    localparam int N_STALL = 100;
    localparam int N_ALU   = 24;
    // Reset reads, fill and sweep, random runs, directed extras
    localparam int NUM_OPS = 64 + 2 * REGION + N_RAND + N_STALL + N_ALU + 72;

    logic        clk;
    logic        reset;
    logic        mem_stall;
    logic        wb_valid;
    exmem_t      exmem;
    logic [4:0]  rf_raddr;
    logic [4:0]  cp0_raddr;
    logic [31:0] rf_rdata;
    logic [31:0] cp0_rdata;

    // Reference model state
    logic [31:0] mem_m [REGION];
    logic [31:0] reg_m [32];
    logic [31:0] cp0_m [32];
    logic [31:0] count_val;
    int          count_edge;
    int          edges  = 0;
    int          errors = 0;
    int          checks = 0;

    tb_clock u_clock (.clk(clk));

    mem_wb_top #(
        .DMEM_ADDR_BITS(10)
    ) uut (
        .clk      (clk),
        .reset    (reset),
        .mem_stall(mem_stall),
        .exmem    (exmem),
        .rf_raddr (rf_raddr),
        .rf_rdata (rf_rdata),
        .cp0_raddr(cp0_raddr),
        .cp0_rdata(cp0_rdata),
        .wb_valid (wb_valid)
    );

    // Rising edges seen by the Count model
    always @(posedge clk) edges <= edges + 1;

    //////////////////////////////////////////////////
    // Model rules
    //////////////////////////////////////////////////

    // Load result merged over the old register value
    function automatic logic [31:0] load_model(input logic [31:0] w, input mem_size_e sz,
                                               input logic sgn, input logic [1:0] k,
                                               input logic [31:0] old);
        logic [31:0] v;
        logic [31:0] keep;
        keep = 32'h0;
        case (sz)
            SIZE_BYTE: begin
                v = (w >> (8 * k)) & 32'hff;
                if (sgn && v[7])
                    v = v | 32'hffff_ff00;
            end
            SIZE_HALF: begin
                v = (w >> (16 * k[1])) & 32'hffff;
                if (sgn && v[15])
                    v = v | 32'hffff_0000;
            end
            SIZE_LEFT: begin
                v    = w << (8 * (3 - k));
                keep = ~(32'hffff_ffff << (8 * (3 - k)));
            end
            SIZE_RIGHT: begin
                v    = w >> (8 * k);
                keep = ~(32'hffff_ffff >> (8 * k));
            end
            default: v = w;
        endcase
        return (v & ~keep) | (old & keep);
    endfunction

    function automatic logic [31:0] store_model(input logic [31:0] w, input mem_size_e sz,
                                                input logic [1:0] k, input logic [31:0] rt);
        logic [31:0] m;
        int          sh;
        case (sz)
            SIZE_BYTE: begin
                m  = 32'hff << (8 * k);
                sh = 8 * k;
            end
            SIZE_HALF: begin
                m  = 32'hffff << (16 * k[1]);
                sh = 16 * k[1];
            end
            default: begin
                m  = 32'hffff_ffff;
                sh = 0;
            end
        endcase
        return (w & ~m) | ((rt << sh) & m);
    endfunction

    function automatic exmem_t make_op(input logic rd_mem, input logic wr_mem,
                                       input logic wr_reg, input mem_size_e sz,
                                       input logic sgn, input logic [4:0] rd,
                                       input logic [31:0] alu, input logic [31:0] rt);
        exmem_t op;
        op             = '0;
        op.mem_r       = rd_mem;
        op.mem_w       = wr_mem;
        op.reg_w       = wr_reg;
        op.size        = sz;
        op.load_signed = sgn;
        op.rd_addr     = rd;
        op.alu_result  = alu;
        op.rt_data     = rt;
        return op;
    endfunction

    //////////////////////////////////////////////////
    // Checks and reads
    //////////////////////////////////////////////////
    task automatic check_eq(input string name, input logic [31:0] expv,
                            input logic [31:0] actv);
        checks++;
        assert (actv === expv) else begin
            errors++;
            $display("[ERROR] %s expected %h actual %h", name, expv, actv);
        end
    endtask

    task automatic read_reg(input logic [4:0] r);
        @(negedge clk);
        rf_raddr = r;
        #1;
        check_eq($sformatf("rf_rdata[r%0d]", r), reg_m[r], rf_rdata);
    endtask

    task automatic read_cp0(input logic [4:0] r);
        logic [31:0] expv;
        @(negedge clk);
        cp0_raddr = r;
        #1;
        // Count runs on from its last written value
        expv = (r == CP0_COUNT) ? count_val + 32'(edges - count_edge) : cp0_m[r];
        check_eq($sformatf("cp0_rdata[%0d]", r), expv, cp0_rdata);
    endtask

    //////////////////////////////////////////////////
    // Execute-stage driver
    //////////////////////////////////////////////////

    // Stall run first then MEM edge E1 and WB edge E2
    task automatic run_op(input exmem_t op, input int stalls);
        logic [1:0] k;
        logic [5:0] wi;
        k  = op.alu_result[1:0];
        wi = op.alu_result[7:2];
        @(negedge clk);
        exmem     = op;
        mem_stall = (stalls > 0);
        repeat (stalls) begin
            @(posedge clk);
            @(negedge clk);
        end
        mem_stall = 1'b0;
        @(posedge clk);
        @(negedge clk);
        exmem = '0;
        // Op now held in MEM/WB
        check_eq("wb_valid", 32'(op.reg_w && op.rd_addr != 5'd0), 32'(wb_valid));
        @(posedge clk);
        @(negedge clk);
        if (op.reg_w && op.rd_addr != 5'd0)
            reg_m[op.rd_addr] = op.mem_r ?
                load_model(mem_m[wi], op.size, op.load_signed, k, reg_m[op.rd_addr]) :
                op.alu_result;
        if (op.mem_w)
            mem_m[wi] = store_model(mem_m[wi], op.size, k, op.rt_data);
        if (op.cp0_w_en) begin
            cp0_m[op.cp0_dst_addr] = op.rt_data;
            if (op.cp0_dst_addr == CP0_COUNT) begin
                count_val  = op.rt_data;
                count_edge = edges;
            end
        end
    endtask

    // Non-memory op kept in MEM/WB by a stall run after E1
    task automatic held_op(input exmem_t op, input int stalls);
        logic active;
        active = op.reg_w && op.rd_addr != 5'd0;
        @(negedge clk);
        exmem     = op;
        mem_stall = 1'b0;
        @(posedge clk);
        @(negedge clk);
        exmem     = '0;
        mem_stall = 1'b1;
        // Held write repeats on every stalled edge
        repeat (stalls) begin
            @(posedge clk);
            @(negedge clk);
            check_eq("wb_valid", 32'(active), 32'(wb_valid));
        end
        mem_stall = 1'b0;
        @(posedge clk);
        @(negedge clk);
        if (active)
            reg_m[op.rd_addr] = op.alu_result;
        if (op.cp0_w_en) begin
            cp0_m[op.cp0_dst_addr] = op.rt_data;
            // Last write lands on the first edge after the stall
            if (op.cp0_dst_addr == CP0_COUNT) begin
                count_val  = op.rt_data;
                count_edge = edges;
            end
        end
    endtask

    // Random store or load in the test region
    task automatic rand_access(input int max_stall);
        logic [31:0] a;
        logic [4:0]  rd;
        mem_size_e   sz;
        a  = 32'($urandom_range(REGION * 4 - 1, 0));
        sz = mem_size_e'($urandom_range(2, 0));
        rd = 5'($urandom_range(31, 1));
        if ($urandom_range(1, 0) == 1) begin
            run_op(make_op(1'b0, 1'b1, 1'b0, sz, 1'b0, 5'd0, a, $urandom()),
                   $urandom_range(max_stall, 0));
        end else begin
            run_op(make_op(1'b1, 1'b0, 1'b1, sz, 1'($urandom_range(1, 0)), rd, a, 32'h0),
                   $urandom_range(max_stall, 0));
            read_reg(rd);
        end
    endtask

    // Store seen only under stall and then withdrawn
    task automatic squashed_store(input int stalls);
        logic [31:0] a;
        a = 32'($urandom_range(REGION - 1, 0)) << 2;
        @(negedge clk);
        exmem     = make_op(1'b0, 1'b1, 1'b0, SIZE_WORD, 1'b0, 5'd0, a, ~mem_m[a[7:2]]);
        mem_stall = 1'b1;
        repeat (stalls) @(negedge clk);
        exmem     = '0;
        mem_stall = 1'b0;
        run_op(make_op(1'b1, 1'b0, 1'b1, SIZE_WORD, 1'b0, 5'd1, a, 32'h0), 0);
        read_reg(5'd1);
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////
    initial begin
        exmem_t      op;
        logic [4:0]  idx;
        logic [31:0] a;
        void'($urandom(32'h014a_a972));
        reset     = 1'b1;
        mem_stall = 1'b0;
        exmem     = '0;
        rf_raddr  = 5'd0;
        cp0_raddr = 5'd0;
        for (int r = 0; r < 32; r++) begin
            reg_m[r] = 32'h0;
            cp0_m[r] = 32'h0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset      = 1'b0;
        count_val  = 32'h0;
        count_edge = edges;

        // Everything clear after reset
        check_eq("wb_valid", 32'h0, 32'(wb_valid));
        for (int r = 0; r < 32; r++) begin
            read_reg(5'(r));
            read_cp0(5'(r));
        end

        // Fill pattern keyed by the whole byte address
        for (int i = 0; i < REGION; i++) begin
            a = 32'(i * 4);
            run_op(make_op(1'b0, 1'b1, 1'b0, SIZE_WORD, 1'b0, 5'd0, a,
                           {a[15:0], ~a[15:0]} ^ 32'h5a3c_96f0), 0);
        end
        repeat (N_RAND) rand_access(0);

        // LWL and LWR at every offset over a known register
        for (int k = 0; k < 4; k++) begin
            for (int left = 0; left < 2; left++) begin
                run_op(make_op(1'b0, 1'b0, 1'b1, SIZE_WORD, 1'b0, 5'd7, 32'hc3a5_0f1e ^ 32'(k),
                               32'h0), 0);
                run_op(make_op(1'b1, 1'b0, 1'b1, (left == 1) ? SIZE_LEFT : SIZE_RIGHT, 1'b0,
                               5'd7, 32'(4 * (3 + k) + k), 32'h0), 0);
                read_reg(5'd7);
            end
        end

        // ALU results, r0 and reg_w clear
        run_op(make_op(1'b0, 1'b0, 1'b1, SIZE_WORD, 1'b0, 5'd0, 32'hdead_beef, 32'h0), 0);
        read_reg(5'd0);
        repeat (N_ALU) begin
            idx = 5'($urandom_range(31, 0));
            run_op(make_op(1'b0, 1'b0, 1'($urandom_range(1, 0)), SIZE_WORD, 1'b0, idx,
                           $urandom(), 32'h0), 0);
            read_reg(idx);
        end

        // Stall runs, squashed stores, then full state sweep
        repeat (N_STALL) rand_access(3);
        for (int i = 1; i <= 8; i++)
            squashed_store(1 + i % 3);
        for (int i = 0; i < REGION; i++) begin
            idx = 5'(1 + i % 31);
            run_op(make_op(1'b1, 1'b0, 1'b1, SIZE_WORD, 1'b0, idx, 32'(i * 4), 32'h0), 0);
            read_reg(idx);
        end
        for (int r = 0; r < 32; r++)
            read_reg(5'(r));

        // Register writes held in MEM/WB under stall
        repeat (8) begin
            idx = 5'($urandom_range(31, 1));
            held_op(make_op(1'b0, 1'b0, 1'b1, SIZE_WORD, 1'b0, idx, $urandom(), 32'h0),
                    $urandom_range(3, 1));
            read_reg(idx);
        end

        // CP0 writes and a running Count after each held write
        repeat (8) begin
            idx = 5'($urandom_range(31, 0));
            if (idx == CP0_COUNT)
                idx = 5'd12;
            op              = make_op(1'b0, 1'b0, 1'b0, SIZE_WORD, 1'b0, 5'd0, 32'h0, $urandom());
            op.cp0_w_en     = 1'b1;
            op.cp0_dst_addr = idx;
            run_op(op, $urandom_range(2, 0));
            read_cp0(idx);
        end
        repeat (3) begin
            op              = make_op(1'b0, 1'b0, 1'b0, SIZE_WORD, 1'b0, 5'd0, 32'h0, $urandom());
            op.cp0_w_en     = 1'b1;
            op.cp0_dst_addr = CP0_COUNT;
            held_op(op, $urandom_range(3, 1));
            repeat ($urandom_range(10, 0)) @(negedge clk);
            read_cp0(CP0_COUNT);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Watchdog at 12 cycles per op
    initial begin
        #(NUM_OPS * 12 * 4);
        $display("Watchdog expired before the test sequence finished");
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Some tests failed");
        $finish;
    end

endmodule

/* dv/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD_NS = 4.0
) (
    output logic clk
);

    // Starts low, first rising edge after half a period
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

endmodule

/* src/mem_wb_top.sv */
`timescale 1ns/1ps

module mem_wb_top import mips_mem_pkg::*; #(
    parameter int DMEM_ADDR_BITS = 10
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        mem_stall,
    input  exmem_t      exmem,
    input  logic [4:0]  rf_raddr,
    output logic [31:0] rf_rdata,
    input  logic [4:0]  cp0_raddr,
    output logic [31:0] cp0_rdata,
    output logic        wb_valid
);

    memwb_t     mem_out;
    memwb_t     memwb;
    rf_write_t  rf_wr;
    cp0_write_t cp0_wr;

    //////////////////////////////////////////////////
    // Memory access
    //////////////////////////////////////////////////
    mem_stage #(
        .DMEM_ADDR_BITS(DMEM_ADDR_BITS)
    ) u_mem_stage (
        .clk      (clk),
        .mem_stall(mem_stall),
        .exmem    (exmem),
        .mem_out  (mem_out)
    );

    memwb_reg u_memwb_reg (
        .clk      (clk),
        .reset    (reset),
        .mem_stall(mem_stall),
        .d        (mem_out),
        .q        (memwb)
    );

    //////////////////////////////////////////////////
    // Write-back
    //////////////////////////////////////////////////
    writeback u_writeback (
        .memwb (memwb),
        .rf_wr (rf_wr),
        .cp0_wr(cp0_wr)
    );

    reg_file u_reg_file (
        .clk  (clk),
        .reset(reset),
        .wr   (rf_wr),
        .raddr(rf_raddr),
        .rdata(rf_rdata)
    );

    cp0_regs u_cp0_regs (
        .clk  (clk),
        .reset(reset),
        .wr   (cp0_wr),
        .raddr(cp0_raddr),
        .rdata(cp0_rdata)
    );

    // Any lane enabled means a register write commits
    assign wb_valid = |rf_wr.byte_w_en;

endmodule

/* src/cp0_regs.sv */
`timescale 1ns/1ps

module cp0_regs import mips_mem_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  cp0_write_t  wr,
    input  logic [4:0]  raddr,
    output logic [31:0] rdata
);

    logic [31:0] regs [32];
    logic        count_written;

    // Write to Count this cycle wins over the increment
    assign count_written = wr.w_en && (wr.addr == CP0_COUNT);

    //////////////////////////////////////////////////
    // CP0 bank
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < 32; r++) begin
                regs[r] <= '0;
            end
        end else begin
            if (wr.w_en) begin
                regs[wr.addr] <= wr.data;
            end
            // Free-running Count
            if (!count_written) begin
                regs[CP0_COUNT] <= regs[CP0_COUNT] + 32'd1;
            end
        end
    end

    // Single combinational read port
    assign rdata = regs[raddr];

endmodule

/* src/reg_file.sv */
`timescale 1ns/1ps

module reg_file import mips_mem_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  rf_write_t   wr,
    input  logic [4:0]  raddr,
    output logic [31:0] rdata
);

    // General registers
    logic [31:0] regs [32];

    //////////////////////////////////////////////////
    // Byte-lane writes
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < 32; r++) begin
                regs[r] <= '0;
            end
        end else if (wr.addr != 5'd0) begin
            // Each enabled lane written independently
            for (int b = 0; b < 4; b++) begin
                if (wr.byte_w_en[b]) begin
                    regs[wr.addr][b*8 +: 8] <= wr.data[b*8 +: 8];
                end
            end
        end
    end

    // Combinational read, r0 forced to zero
    assign rdata = (raddr == 5'd0) ? 32'h0 : regs[raddr];

endmodule

/* src/writeback.sv */
`timescale 1ns/1ps

module writeback import mips_mem_pkg::*; (
    input  memwb_t     memwb,
    output rf_write_t  rf_wr,
    output cp0_write_t cp0_wr
);

    logic rf_active;

    //////////////////////////////////////////////////
    // Register file request
    //////////////////////////////////////////////////

    // No write for reg_w clear or r0 target
    assign rf_active = memwb.reg_w && (memwb.rd_addr != 5'd0);

    assign rf_wr.byte_w_en = rf_active ? memwb.byte_w_en : 4'b0000;
    assign rf_wr.addr      = memwb.rd_addr;
    // Load data already lane-aligned, LWL/LWR included
    assign rf_wr.data      = memwb.mem_r ? memwb.mem_data : memwb.ex_data;

    //////////////////////////////////////////////////
    // CP0 request
    //////////////////////////////////////////////////
    assign cp0_wr.w_en = memwb.cp0_w_en;
    assign cp0_wr.addr = memwb.cp0_dst_addr;
    assign cp0_wr.data = memwb.aligned_rt_data;

endmodule

/* src/memwb_reg.sv */
`timescale 1ns/1ps

module memwb_reg import mips_mem_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   mem_stall,
    input  memwb_t d,
    output memwb_t q
);

    //////////////////////////////////////////////////
    // MEM/WB pipeline register
    //////////////////////////////////////////////////

    // Cleared contents mean no write-back activity
    always_ff @(posedge clk) begin
        if (reset) begin
            q <= '0;
        end else if (!mem_stall) begin
            q <= d;
        end
        // Stalled, hold previous contents
    end

endmodule

/* src/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage import mips_mem_pkg::*; #(
    parameter int DMEM_ADDR_BITS = 10
) (
    input  logic   clk,
    input  logic   mem_stall,
    input  exmem_t exmem,
    output memwb_t mem_out
);

    // Data memory, no reset
    logic [31:0] dmem [2**DMEM_ADDR_BITS];

    logic [DMEM_ADDR_BITS-1:0] word_addr;
    logic [1:0]                k;
    mem_word_u                 st_word;
    logic [3:0]                st_mask;
    mem_word_u                 rd_word;
    mem_word_u                 ld_word;
    logic [3:0]                ld_en;

    // Word address and byte offset
    assign word_addr = exmem.alu_result[DMEM_ADDR_BITS+1:2];
    assign k         = exmem.alu_result[1:0];

    //////////////////////////////////////////////////
    // Store lane placement
    //////////////////////////////////////////////////
    always_comb begin
        st_word = '0;
        st_mask = 4'b0000;
        case (exmem.size)
            SIZE_BYTE: begin
                st_word.bytes[k] = exmem.rt_data[7:0];
                st_mask[k]       = 1'b1;
            end
            SIZE_HALF: begin
                // Low offset bit ignored
                st_word.halves[k[1]]   = exmem.rt_data[15:0];
                st_mask[k[1]*2 +: 2]   = 2'b11;
            end
            SIZE_WORD: begin
                st_word = exmem.rt_data;
                st_mask = 4'b1111;
            end
            default: st_mask = 4'b0000;
        endcase
    end

    // Byte-masked commit, held off while stalled
    always_ff @(posedge clk) begin
        if (exmem.mem_w && !mem_stall) begin
            for (int i = 0; i < 4; i++) begin
                if (st_mask[i]) begin
                    dmem[word_addr][i*8 +: 8] <= st_word.bytes[i];
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Load extraction and extension
    //////////////////////////////////////////////////
    assign rd_word = dmem[word_addr];

    always_comb begin
        ld_word = '0;
        ld_en   = 4'b1111;
        case (exmem.size)
            SIZE_BYTE: begin
                ld_word.bytes[0] = rd_word.bytes[k];
                ld_word[31:8]    = {24{exmem.load_signed & rd_word.bytes[k][7]}};
            end
            SIZE_HALF: begin
                ld_word.halves[0] = rd_word.halves[k[1]];
                ld_word[31:16]    = {16{exmem.load_signed & rd_word.halves[k[1]][15]}};
            end
            SIZE_LEFT: begin
                // Mem bytes k..0 into reg bytes 3..3-k
                ld_en = 4'b0000;
                for (int i = 0; i < 4; i++) begin
                    if (i <= int'(k)) begin
                        ld_word.bytes[3 - int'(k) + i] = rd_word.bytes[i];
                        ld_en[3 - int'(k) + i]         = 1'b1;
                    end
                end
            end
            SIZE_RIGHT: begin
                // Mem bytes 3..k into reg bytes 3-k..0
                ld_en = 4'b0000;
                for (int i = 0; i < 4; i++) begin
                    if (i >= int'(k)) begin
                        ld_word.bytes[i - int'(k)] = rd_word.bytes[i];
                        ld_en[i - int'(k)]         = 1'b1;
                    end
                end
            end
            default: ld_word = rd_word;
        endcase
    end

    // Stage output toward MEM/WB
    always_comb begin
        mem_out.mem_r        = exmem.mem_r;
        mem_out.reg_w        = exmem.reg_w;
        // Partial enables only for loads
        mem_out.byte_w_en    = !exmem.reg_w ? 4'b0000 :
                               (exmem.mem_r ? ld_en : 4'b1111);
        mem_out.rd_addr      = exmem.rd_addr;
        mem_out.mem_data     = ld_word;
        mem_out.ex_data      = exmem.alu_result;
        mem_out.cp0_dst_addr = exmem.cp0_dst_addr;
        mem_out.cp0_w_en     = exmem.cp0_w_en;
        mem_out.aligned_rt_data = exmem.mem_w ? st_word : exmem.rt_data;
    end

endmodule

/* src/mips_mem_pkg.sv */
package mips_mem_pkg;

    //////////////////////////////////////////////////
    // Access kinds
    //////////////////////////////////////////////////
    typedef enum logic [2:0] {
        SIZE_BYTE  = 3'd0,
        SIZE_HALF  = 3'd1,
        SIZE_WORD  = 3'd2,
        SIZE_LEFT  = 3'd3,  // LWL
        SIZE_RIGHT = 3'd4   // LWR
    } mem_size_e;

    // CP0 Count register index
    localparam logic [4:0] CP0_COUNT = 5'd9;

    //////////////////////////////////////////////////
    // Stage structs
    //////////////////////////////////////////////////
    typedef struct packed {
        logic        mem_r;
        logic        mem_w;
        logic        reg_w;
        mem_size_e   size;
        logic        load_signed;
        logic [4:0]  rd_addr;
        logic [31:0] alu_result;    // Memory address or execute data
        logic [31:0] rt_data;
        logic        cp0_w_en;
        logic [4:0]  cp0_dst_addr;
    } exmem_t;

    typedef struct packed {
        logic        mem_r;
        logic        reg_w;
        logic [3:0]  byte_w_en;
        logic [4:0]  rd_addr;
        logic [31:0] mem_data;
        logic [31:0] ex_data;
        logic [4:0]  cp0_dst_addr;
        logic        cp0_w_en;
        logic [31:0] aligned_rt_data;
    } memwb_t;

    // Register file write request
    typedef struct packed {
        logic [3:0]  byte_w_en;
        logic [4:0]  addr;
        logic [31:0] data;
    } rf_write_t;

    // CP0 write request
    typedef struct packed {
        logic        w_en;
        logic [4:0]  addr;
        logic [31:0] data;
    } cp0_write_t;

    // One memory word, by byte lane or by half lane
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } mem_word_u;

endpackage
